//--- logic/audio_pkg.sv
`default_nettype none

package audio_pkg;

    typedef logic signed [15:0] sample_t;   // Signed audio sample
    typedef logic        [15:0] mag_t;      // Unsigned magnitude, abs value or peak
    typedef logic        [3:0]  thresh_t;   // Threshold code, top bits of a magnitude

    localparam int WIN_DEPTH    = 4;        // Look-ahead taps, newest to oldest
    localparam int THRESH_SHIFT = 11;       // Threshold code lands on mag bits 14..11
    localparam int FACTOR_W     = 4;        // Excess bits used as multiplier

    localparam thresh_t RESET_THRESH = thresh_t'(15);  // Max code, compression idle

    // Two's-complement magnitude
    // -32768 wraps to 0x8000, inputs are kept inside +/-32767
    function automatic mag_t abs_mag(input sample_t s);
        mag_t m;
        if (s[15]) begin
            m = mag_t'(-s);                 // Negate negative sample
        end else begin
            m = mag_t'(s);                  // Positive passes as is
        end
        return m;
    endfunction

endpackage

`default_nettype wire

//--- logic/window_if.sv
`timescale 1ns/1ps
`default_nettype none

interface window_if;
    import audio_pkg::*;

    sample_t tap0;                          // Newest sample
    sample_t tap1;
    sample_t tap2;
    sample_t tap3;                          // Oldest sample, the one compressed

    modport producer (
        output tap0,
        output tap1,
        output tap2,
        output tap3
    );

    modport consumer (
        input tap0,
        input tap1,
        input tap2,
        input tap3
    );

endinterface

`default_nettype wire

//--- logic/sample_window.sv
`timescale 1ns/1ps
`default_nettype none

module sample_window (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              shift,        // Advance strobe from control
    input  audio_pkg::sample_t sample_in,
    window_if.producer        win
);
    import audio_pkg::*;

    sample_t taps [WIN_DEPTH];              // taps[0] newest, taps[WIN_DEPTH-1] oldest

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < WIN_DEPTH; i++) begin
                taps[i] <= '0;              // Window starts silent
            end
        end else if (shift) begin
            taps[0] <= sample_in;           // New sample enters at the front
            for (int i = 1; i < WIN_DEPTH; i++) begin
                taps[i] <= taps[i-1];       // Everything ages by one
            end
        end
        // Between strobes the history is held
    end

    assign win.tap0 = taps[0];
    assign win.tap1 = taps[1];
    assign win.tap2 = taps[2];
    assign win.tap3 = taps[WIN_DEPTH-1];    // Oldest entry feeds the gain stage

endmodule

`default_nettype wire

//--- logic/peak_detect.sv
`timescale 1ns/1ps
`default_nettype none

module peak_detect (
    window_if.consumer     win,
    output audio_pkg::mag_t peak            // Largest magnitude in the window
);
    import audio_pkg::*;

    mag_t mag0;                             // Per-tap magnitudes
    mag_t mag1;
    mag_t mag2;
    mag_t mag3;

    mag_t max01;                            // First level of the compare tree
    mag_t max23;

    assign mag0 = abs_mag(win.tap0);
    assign mag1 = abs_mag(win.tap1);
    assign mag2 = abs_mag(win.tap2);
    assign mag3 = abs_mag(win.tap3);

    // Pairwise compare, newer pair and older pair
    always_comb begin
        if (mag0 >= mag1) begin
            max01 = mag0;
        end else begin
            max01 = mag1;
        end

        if (mag2 >= mag3) begin
            max23 = mag2;
        end else begin
            max23 = mag3;
        end
    end

    // Final compare of the two pair winners
    always_comb begin
        if (max01 >= max23) begin
            peak = max01;
        end else begin
            peak = max23;
        end
    end

endmodule

`default_nettype wire

//--- logic/gain_reducer.sv
`timescale 1ns/1ps
`default_nettype none

module gain_reducer (
    input  logic               clk,
    input  logic               rst_n,
    window_if.consumer         win,
    input  audio_pkg::mag_t    peak,        // Window peak magnitude
    input  audio_pkg::thresh_t thresh,      // Threshold code from control
    input  logic               bypass,      // Pass tap3 unchanged
    input  logic               out_load,    // Capture strobe from control
    output audio_pkg::sample_t out_sample
);
    import audio_pkg::*;

    localparam int MAG_W  = $bits(mag_t);
    localparam int PROD_W = MAG_W + FACTOR_W;   // 16 x 4 bit product

    mag_t                thresh_mag;        // Threshold as a magnitude
    logic [MAG_W:0]      excess;            // Peak minus threshold, MSB is sign
    logic                over;              // Peak at or above threshold
    logic [FACTOR_W-1:0] factor;            // Top bits of the excess
    mag_t                tap3_mag;
    logic [PROD_W-1:0]   product;
    mag_t                modifier;          // Amount pulled toward zero
    sample_t             mod_s;
    sample_t             processed;

    assign thresh_mag = mag_t'(thresh) << THRESH_SHIFT;
    assign excess     = {1'b0, peak} - {1'b0, thresh_mag};
    assign over       = ~excess[MAG_W];     // Negative excess means no compression
    assign factor     = excess[THRESH_SHIFT+FACTOR_W-1:THRESH_SHIFT];

    assign tap3_mag = abs_mag(win.tap3);
    assign product  = PROD_W'(tap3_mag) * PROD_W'(factor);

    // Normalize by the leading bit of the peak, bit 14 down to bit 11
    // Ascending scan so the highest set bit wins
    always_comb begin
        modifier = '0;
        if (over) begin
            for (int b = THRESH_SHIFT; b < THRESH_SHIFT + FACTOR_W; b++) begin
                if (peak[b]) begin
                    modifier = mag_t'(product >> (b + 1));  // Bit 14 gives >> 15
                end
            end
        end
    end

    assign mod_s = sample_t'(modifier);     // Small positive value, fits signed

    // Move tap3 toward zero
    always_comb begin
        if (bypass) begin
            processed = win.tap3;
        end else if (win.tap3[15]) begin
            processed = win.tap3 + mod_s;   // Negative sample rises
        end else begin
            processed = win.tap3 - mod_s;   // Positive sample falls
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_sample <= '0;
        end else if (out_load) begin
            out_sample <= processed;        // Held until the next load
        end
    end

endmodule

`default_nettype wire

//--- logic/comp_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module comp_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sample_en,   // One cycle per accepted sample
    input  logic               thresh_we,
    input  audio_pkg::thresh_t thresh_in,
    input  logic               bypass_in,   // Level input sampled every clock
    output logic               shift,       // Window advance
    output logic               out_load,    // Output register capture
    output logic               out_valid,   // Aligned with out_sample
    output audio_pkg::thresh_t thresh,
    output logic               bypass
);
    import audio_pkg::*;

    localparam int CNT_W = $clog2(WIN_DEPTH + 1);

    logic [CNT_W-1:0] fill_cnt;             // Saturating count of samples in the window
    logic [CNT_W-1:0] fill_nxt;
    logic             full_nxt;             // Window full after this strobe

    assign shift = sample_en;               // Window moves on each accepted sample

    always_comb begin
        if (fill_cnt == CNT_W'(WIN_DEPTH)) begin
            fill_nxt = fill_cnt;            // Stays at full
        end else begin
            fill_nxt = fill_cnt + CNT_W'(1);
        end
    end

    assign full_nxt = (fill_nxt == CNT_W'(WIN_DEPTH));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt  <= '0;
            out_load  <= 1'b0;
            out_valid <= 1'b0;
            thresh    <= RESET_THRESH;
            bypass    <= 1'b0;
        end else begin
            if (sample_en) begin
                fill_cnt <= fill_nxt;
            end
            out_load  <= sample_en && full_nxt;     // Load one cycle after the strobe
            out_valid <= out_load;                  // Pulse with the new output value
            if (thresh_we) begin
                thresh <= thresh_in;
            end
            bypass <= bypass_in;
        end
    end

endmodule

`default_nettype wire

//--- logic/amp_compressor.sv
`timescale 1ns/1ps
`default_nettype none

module amp_compressor (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sample_en,
    input  audio_pkg::sample_t sample_in,
    input  logic               thresh_we,
    input  audio_pkg::thresh_t thresh_in,
    input  logic               bypass_in,
    output audio_pkg::sample_t out_sample,
    output logic               out_valid
);
    import audio_pkg::*;

    logic    shift;                         // Control to window
    logic    out_load;                      // Control to gain stage
    thresh_t thresh;
    logic    bypass;
    mag_t    peak;                          // Peak detector to gain stage

    window_if win_bus ();                   // Four taps, window to consumers

    comp_ctrl comp_ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en),
        .thresh_we (thresh_we),
        .thresh_in (thresh_in),
        .bypass_in (bypass_in),
        .shift     (shift),
        .out_load  (out_load),
        .out_valid (out_valid),
        .thresh    (thresh),
        .bypass    (bypass)
    );

    sample_window sample_window_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (shift),
        .sample_in (sample_in),
        .win       (win_bus.producer)
    );

    peak_detect peak_detect_inst (
        .win  (win_bus.consumer),
        .peak (peak)
    );

    gain_reducer gain_reducer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .win        (win_bus.consumer),
        .peak       (peak),
        .thresh     (thresh),
        .bypass     (bypass),
        .out_load   (out_load),
        .out_sample (out_sample)
    );

endmodule

`default_nettype wire

//--- test/tb_amp_compressor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_amp_compressor;
    import audio_pkg::*;

    typedef struct packed {
        logic    en;
        sample_t s;
        logic    we;
        thresh_t t;
        logic    byp;
        logic    ev;                        // Output expected from this strobe
        sample_t es;
    } row_t;

    localparam int N_ROWS         = 30;
    localparam int N_RAND         = 64;
    localparam int TIMEOUT_CYCLES = N_ROWS + N_RAND * 2 + 20;

    logic    clk;
    logic    rst_n;
    logic    sample_en;
    sample_t sample_in;
    logic    thresh_we;
    thresh_t thresh_in;
    logic    bypass_in;
    sample_t out_sample;
    logic    out_valid;

    int          cycle_cnt = 0;
    int          check_cnt = 0;
    int          err_cnt = 0;
    int          err_start;
    logic [15:0] lfsr_state = 16'd833;
    logic [15:0] bits;
    sample_t     rs;
    sample_t     win_m [4];                 // Model window, [0] newest
    int          fill_m;
    thresh_t     thresh_m;
    logic        pipe_v [3];                // Expectations in flight, [2] due now
    sample_t     pipe_s [3];
    sample_t     pipe_r [3];                // Raw tap3 behind each expectation

    // Columns en, sample_in, thresh_we, thresh_in, bypass_in, expect valid, expected out
    row_t rows [N_ROWS] = '{
        '{1'b1, 16'sd100,     1'b0, 4'd0,  1'b0, 1'b0, 16'sd0},
        '{1'b0, 16'sd0,       1'b0, 4'd0,  1'b0, 1'b0, 16'sd0},      // Idle, window held
        '{1'b1, -16'sd200,    1'b0, 4'd0,  1'b0, 1'b0, 16'sd0},
        '{1'b1, 16'sd300,     1'b0, 4'd0,  1'b0, 1'b0, 16'sd0},
        '{1'b0, 16'sd0,       1'b0, 4'd0,  1'b0, 1'b0, 16'sd0},
        '{1'b1, -16'sd400,    1'b0, 4'd0,  1'b0, 1'b1, 16'sd100},    // Window full
        '{1'b0, 16'sd0,       1'b0, 4'd0,  1'b0, 1'b0, 16'sd0},
        '{1'b1, 16'sd1000,    1'b0, 4'd0,  1'b0, 1'b1, -16'sd200},
        '{1'b1, -16'sd2000,   1'b0, 4'd0,  1'b0, 1'b1, 16'sd300},
        '{1'b1, 16'sd20000,   1'b0, 4'd0,  1'b0, 1'b1, -16'sd400},   // Below 30720
        '{1'b1, 16'sd32000,   1'b1, 4'd0,  1'b0, 1'b1, 16'sd1000},   // Threshold to 0
        '{1'b1, -16'sd32000,  1'b0, 4'd0,  1'b0, 1'b1, -16'sd2000},
        '{1'b1, 16'sd25000,   1'b0, 4'd0,  1'b0, 1'b1, 16'sd19991},
        '{1'b1, -16'sd30000,  1'b0, 4'd0,  1'b0, 1'b1, 16'sd31986},
        '{1'b1, 16'sd100,     1'b0, 4'd0,  1'b0, 1'b1, -16'sd31986},
        '{1'b1, 16'sd200,     1'b0, 4'd0,  1'b0, 1'b1, 16'sd24990},
        '{1'b1, 16'sd300,     1'b0, 4'd0,  1'b0, 1'b1, -16'sd29988},
        '{1'b1, -16'sd6000,   1'b0, 4'd0,  1'b0, 1'b1, 16'sd100},
        '{1'b1, 16'sd32767,   1'b0, 4'd0,  1'b0, 1'b1, 16'sd200},
        '{1'b1, -16'sd32767,  1'b0, 4'd0,  1'b0, 1'b1, 16'sd300},
        '{1'b1, 16'sd32767,   1'b0, 4'd0,  1'b0, 1'b1, -16'sd5998},
        '{1'b1, 16'sd32767,   1'b0, 4'd0,  1'b0, 1'b1, 16'sd32753},
        '{1'b1, -16'sd32767,  1'b1, 4'd8,  1'b0, 1'b1, -16'sd32761}, // Reload to 8
        '{1'b1, 16'sd32767,   1'b0, 4'd0,  1'b0, 1'b1, 16'sd32761},
        '{1'b1, 16'sd32767,   1'b1, 4'd15, 1'b0, 1'b1, 16'sd32767},  // Excess too small
        '{1'b1, -16'sd32767,  1'b1, 4'd0,  1'b1, 1'b1, -16'sd32767}, // Bypass above threshold
        '{1'b1, 16'sd32767,   1'b0, 4'd0,  1'b1, 1'b1, 16'sd32767},
        '{1'b1, 16'sd0,       1'b0, 4'd0,  1'b0, 1'b1, 16'sd32753},  // Bypass off again
        '{1'b0, 16'sd0,       1'b0, 4'd0,  1'b0, 1'b0, 16'sd0},
        '{1'b0, 16'sd0,       1'b0, 4'd0,  1'b0, 1'b0, 16'sd0}
    };

    amp_compressor amp_compressor_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample_en  (sample_en),
        .sample_in  (sample_in),
        .thresh_we  (thresh_we),
        .thresh_in  (thresh_in),
        .bypass_in  (bypass_in),
        .out_sample (out_sample),
        .out_valid  (out_valid)
    );

    always #50 clk = ~clk;                  // 100 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) next = next ^ 16'hB400;   // Taps 16, 14, 13, 11
        return next;
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state); // One step per bit taken
            val = {val[14:0], lfsr_state[0]};
        end
    endtask

    function automatic int mag_of(input sample_t s);
        return (s < 0) ? -int'(s) : int'(s);
    endfunction

    // Compression of the sample leaving the window, t3 oldest
    function automatic sample_t compress_ref(input sample_t t0, input sample_t t1,
                                             input sample_t t2, input sample_t t3,
                                             input thresh_t th, input logic byp);
        int peak;
        int excess;
        int shamt;
        int modv;
        peak = mag_of(t0);
        if (mag_of(t1) > peak) peak = mag_of(t1);
        if (mag_of(t2) > peak) peak = mag_of(t2);
        if (mag_of(t3) > peak) peak = mag_of(t3);
        excess = peak - int'(th) * 2048;    // Code counts in steps of 2048
        if (byp || excess < 0) return t3;
        if (peak >= 16384) shamt = 15;
        else if (peak >= 8192) shamt = 14;
        else if (peak >= 4096) shamt = 13;
        else if (peak >= 2048) shamt = 12;
        else shamt = 0;                     // Leading bit below 11, no pull
        modv = (shamt == 0) ? 0 : (mag_of(t3) * ((excess / 2048) % 16)) >> shamt;
        return (t3 < 0) ? sample_t'(int'(t3) + modv) : sample_t'(int'(t3) - modv);
    endfunction

    task automatic check(input string name, input logic [15:0] actual,
                         input logic [15:0] expected);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, actual, expected, $time);
        end
    endtask

    // One clock of stimulus, model update and check of the output due now
    task automatic apply_cycle(input logic en, input sample_t s, input logic we,
                               input thresh_t t, input logic byp, input logic use_model,
                               input logic tab_v, input sample_t tab_s);
        @(posedge clk);
        sample_en <= en;
        sample_in <= s;
        thresh_we <= we;
        thresh_in <= t;
        bypass_in <= byp;
        if (en) begin
            for (int i = 3; i > 0; i--) win_m[i] = win_m[i-1];
            win_m[0] = s;
            if (fill_m < 4) fill_m++;
        end
        if (we) thresh_m = t;
        for (int i = 2; i > 0; i--) begin
            pipe_v[i] = pipe_v[i-1];
            pipe_s[i] = pipe_s[i-1];
            pipe_r[i] = pipe_r[i-1];
        end
        pipe_v[0] = use_model ? (en && fill_m == 4) : tab_v;
        pipe_s[0] = use_model ? compress_ref(win_m[0], win_m[1], win_m[2], win_m[3],
                                             thresh_m, byp) : tab_s;
        pipe_r[0] = win_m[3];
        @(negedge clk);                     // Outputs settled mid-cycle
        check("out_valid", 16'(out_valid), 16'(pipe_v[2]));
        if (pipe_v[2]) begin
            check("out_sample", out_sample, pipe_s[2]);
            check("out_sample magnitude bound",
                  16'(mag_of(out_sample) <= mag_of(pipe_r[2])), 16'd1);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        sample_en = 1'b0;
        sample_in = '0;
        thresh_we = 1'b0;
        thresh_in = '0;
        bypass_in = 1'b0;
        fill_m    = 0;
        thresh_m  = 4'd15;                  // Control comes out of reset at code 15
        for (int i = 0; i < 4; i++) win_m[i] = '0;
        for (int i = 0; i < 3; i++) begin
            pipe_v[i] = 1'b0;
            pipe_s[i] = '0;
            pipe_r[i] = '0;
        end

        err_start = err_cnt;
        repeat (5) begin
            @(negedge clk);
            check("out_valid", 16'(out_valid), 16'd0);
            check("out_sample", out_sample, 16'd0);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("out_valid", 16'(out_valid), 16'd0);
        check("out_sample", out_sample, 16'd0);
        $display("reset test done, %0d errors", err_cnt - err_start);

        err_start = err_cnt;
        for (int i = 0; i < N_ROWS; i++) begin
            apply_cycle(rows[i].en, rows[i].s, rows[i].we, rows[i].t, rows[i].byp,
                        1'b0, rows[i].ev, rows[i].es);
        end
        $display("directed table test done, %0d errors", err_cnt - err_start);

        err_start = err_cnt;
        for (int n = 0; n < N_RAND; n++) begin
            draw_bits(16, bits);
            rs = sample_t'(bits);
            if (rs == sample_t'(16'h8000)) rs = -16'sd32767;
            if (n % 4 == 0) draw_bits(4, bits); // New threshold every fourth strobe
            apply_cycle(1'b1, rs, n % 4 == 0, bits[3:0], n >= 48 && n < 52,
                        1'b1, 1'b0, 16'sd0);
        end
        apply_cycle(1'b0, 16'sd0, 1'b0, 4'd0, 1'b0, 1'b1, 1'b0, 16'sd0);
        apply_cycle(1'b0, 16'sd0, 1'b0, 4'd0, 1'b0, 1'b1, 1'b0, 16'sd0);
        $display("random back-to-back test done, %0d errors", err_cnt - err_start);

        $display("checks %0d, passed %0d, failed %0d", check_cnt, check_cnt - err_cnt,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- amp_compressor.f
logic/audio_pkg.sv
logic/window_if.sv
logic/sample_window.sv
logic/peak_detect.sv
logic/gain_reducer.sv
logic/comp_ctrl.sv
logic/amp_compressor.sv
test/tb_amp_compressor.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_amp_compressor
FILELIST  ?= amp_compressor.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
